// File: osd_trace_unit.f
+incdir+verilog
verilog/dii_pkg.sv
verilog/trace_pkg.sv
verilog/stream_fifo.sv
verilog/trace_cfg_apb.sv
verilog/trace_overflow_tracker.sv
verilog/osd_trace_packetization.sv
verilog/osd_trace_unit.sv
verif/trace_checker.sv
verif/osd_trace_unit_tb.sv

// File: verif/osd_trace_unit_tb.sv
`timescale 1ns/100ps
`include "trace_consts.svh"

module osd_trace_unit_tb
   import dii_pkg::*;
();

   typedef struct packed {
      logic [2:0]  test;
      logic [1:0]  kind;  // 0 read, 1 write, 2 read of the drop total against the model.
      logic [3:0]  addr;
      logic [31:0] value; // write data, or the expected read data.
      logic        err;
      logic [7:0]  burst;
      logic [3:0]  gap;
      logic [1:0]  bp;    // 0 ready high, 1 random ready, 2 ready low for the burst.
   } row_t;

   localparam int NUM_ROWS = 18;

   logic clk;
   logic rst;
   apb_req_t apb;
   apb_rsp_t apb_rsp;
   logic [`TRACE_WIDTH-1:0] trace_data;
   logic trace_valid;
   dii_flit debug_out;
   logic debug_out_ready;
   logic model_en;
   logic [9:0] model_id;
   logic [15:0] model_dest;
   row_t rows [NUM_ROWS];
   integer seed = 50;
   int total_cycles = 0;

   osd_trace_unit dut0 (
      .clk(clk), .rst(rst), .apb_in(apb), .apb_out(apb_rsp), .trace_data(trace_data),
      .trace_valid(trace_valid), .debug_out(debug_out), .debug_out_ready(debug_out_ready)
   );

   trace_checker chk0 (
      .clk(clk), .rst(rst), .en(model_en), .id_exp(model_id), .dest_exp(model_dest),
      .trace_data(trace_data), .trace_valid(trace_valid), .debug_out(debug_out),
      .debug_out_ready(debug_out_ready)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic logic random_bit();
      logic [31:0] r;
      r = $random(seed);
      return r[0];
   endfunction

   task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                             output logic [31:0] rdata, output logic err);
      @(posedge clk);
      apb <= '{1'b1, 1'b0, wr, addr, wdata};
      @(posedge clk);
      apb.penable <= 1'b1;
      @(negedge clk);
      rdata = apb_rsp.prdata;
      err = apb_rsp.pslverr;
      chk0.check_value("apb_out.pready", 32'd1, apb_rsp.pready);
      @(posedge clk);
      apb <= '0;
      if (wr && addr == `REG_ID) model_id <= wdata[9:0];
      if (wr && addr == `REG_CTRL) model_en <= wdata[0];
      if (wr && addr == `REG_DEST) model_dest <= wdata[15:0];
   endtask

   task automatic run_row(input row_t r);
      logic [31:0] rdata;
      logic err;
      int quiet;
      apb_access(r.kind == 2'd1, r.addr, r.value, rdata, err);
      chk0.check_value("apb_out.pslverr", r.err, err);
      if (r.kind == 2'd0) chk0.check_value("apb_out.prdata", r.value, rdata);
      if (r.kind == 2'd2) chk0.check_value("apb_out.prdata", chk0.sent_cnt - chk0.rcv_cnt, rdata);
      for (int e = 0; e < r.burst; e++) begin
         @(posedge clk);
         trace_data <= $random(seed);
         trace_valid <= 1'b1;
         debug_out_ready <= (r.bp == 2'd1) ? random_bit() : (r.bp == 2'd0);
         repeat (r.gap) begin
            @(posedge clk);
            trace_valid <= 1'b0;
            if (r.bp == 2'd1) debug_out_ready <= random_bit();
         end
      end
      @(posedge clk);
      trace_valid <= 1'b0;
      debug_out_ready <= 1'b1;
      quiet = 0;
      while (quiet < 16) begin // the unit has drained once the output stays idle.
         @(posedge clk);
         quiet = debug_out.valid ? 0 : quiet + 1;
      end
   endtask

   initial begin
      rows[0] = '{1, 0, `REG_ID, 0, 0, 0, 0, 0};
      rows[1] = '{1, 0, `REG_DEST, 0, 0, 0, 0, 0};
      rows[2] = '{1, 0, `REG_CTRL, 0, 0, 0, 0, 0};
      rows[3] = '{1, 1, `REG_ID, 32'h2A5, 0, 0, 0, 0};
      rows[4] = '{1, 1, `REG_DEST, 32'hBEEF, 0, 0, 0, 0};
      rows[5] = '{1, 1, `REG_CTRL, 1, 0, 0, 0, 0};
      rows[6] = '{1, 1, 4'h2, 32'h3FF, 1, 0, 0, 0}; // unaligned offset.
      rows[7] = '{1, 1, `REG_DROPPED, 32'h55, 1, 0, 0, 0};
      rows[8] = '{1, 0, `REG_ID, 32'h2A5, 0, 0, 0, 0};
      rows[9] = '{1, 0, `REG_DEST, 32'hBEEF, 0, 0, 0, 0};
      rows[10] = '{1, 0, `REG_CTRL, 1, 0, 0, 0, 0};
      rows[11] = '{2, 2, `REG_DROPPED, 0, 0, 6, 8, 0};
      rows[12] = '{2, 0, `REG_DROPPED, 0, 0, 0, 0, 0}; // sparse events never overflow.
      rows[13] = '{3, 0, `REG_ID, 32'h2A5, 0, 24, 6, 1};
      rows[14] = '{4, 0, `REG_DEST, 32'hBEEF, 0, 40, 0, 2};
      rows[15] = '{5, 2, `REG_DROPPED, 0, 0, 0, 0, 0};
      rows[16] = '{6, 1, `REG_CTRL, 0, 0, 10, 0, 0};
      rows[17] = '{6, 2, `REG_DROPPED, 0, 0, 0, 0, 0};
      foreach (rows[i]) total_cycles += 24 + rows[i].burst * (rows[i].gap + 1);
      rst <= 1'b1;
      apb <= '0;
      trace_data <= '0;
      trace_valid <= 1'b0;
      debug_out_ready <= 1'b1;
      model_en <= 1'b0;
      model_id <= '0;
      model_dest <= '0;
      repeat (4) @(posedge clk);
      rst <= 1'b0;
      for (int i = 0; i < NUM_ROWS; i++) begin
         run_row(rows[i]);
         if (i == NUM_ROWS - 1 || rows[i + 1].test != rows[i].test) begin
            chk0.finish_test(rows[i].test);
         end
      end
      $display("tests passed: %0d, tests failed: %0d", chk0.pass_cnt, chk0.fail_cnt);
      if (chk0.fail_cnt == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

   initial begin
      wait (total_cycles > 0);
      repeat (total_cycles * 4 + 1000) @(posedge clk);
      $display("the run hung and did not finish within %0d cycles", total_cycles * 4 + 1000);
      $display("Test failed");
      $finish;
   end

endmodule

// File: verif/trace_checker.sv
`timescale 1ns/100ps
`include "trace_consts.svh"

module trace_checker
   import dii_pkg::*;
(
   input logic                    clk,
   input logic                    rst,
   input logic                    en,
   input logic [9:0]              id_exp,
   input logic [15:0]             dest_exp,
   input logic [`TRACE_WIDTH-1:0] trace_data,
   input logic                    trace_valid,
   input dii_flit                 debug_out,
   input logic                    debug_out_ready
);

   logic [`TRACE_WIDTH-1:0] sent_q [$];
   logic [15:0] pkt [4];
   dii_flit held_flit;
   logic held = 1'b0;
   int n_flits = 0;
   int errs = 0;
   int pass_cnt = 0;
   int fail_cnt = 0;
   int sent_cnt = 0;
   int rcv_cnt = 0;
   int status_sum = 0;
   int unmatched_drops = 0;

   task automatic check_value(input string sig, input logic [31:0] exp, input logic [31:0] got);
      if (exp !== got) begin
         $display("[ERROR] at %0d ns %s expected %h received %h", $time, sig, exp, got);
         errs++;
      end
   endtask

   task automatic note_failure(input string what);
      $display("at %0d ns %s", $time, what);
      errs++;
   endtask

   task automatic check_packet();
      logic [9:0] count;
      logic [`TRACE_WIDTH-1:0] data;
      logic ovf;
      int skipped;
      ovf = (n_flits == 3); // overflow packets carry one status flit.
      count = pkt[2][9:0];
      data = {pkt[3], pkt[2]}; // low half arrives first.
      skipped = 0;
      check_value("debug_out.data (destination)", dest_exp, pkt[0]);
      check_value("debug_out.data (source)", {2'b10, 2'b00, ovf, 1'b0, id_exp}, pkt[1]);
      if (ovf) begin
         check_value("debug_out.data (status flag)", 6'b100000, pkt[2][15:10]);
         if (count == 0) note_failure("overflow packet reports zero dropped events");
         status_sum += count;
         unmatched_drops += count;
      end else begin
         // events that were skipped over here were dropped inside the unit.
         while (sent_q.size() > 0 && sent_q[0] !== data) begin
            void'(sent_q.pop_front());
            skipped++;
         end
         if (sent_q.size() == 0) begin
            note_failure("received an event that was never sent or came out of order");
         end else begin
            void'(sent_q.pop_front());
            rcv_cnt++;
            check_value("debug_out.data (status count)", skipped, unmatched_drops);
         end
         unmatched_drops = 0;
      end
   endtask

   task automatic finish_test(input int num);
      if (sent_cnt != rcv_cnt + status_sum) begin
         note_failure("sent events differ from received events plus reported drops");
      end
      check_value("debug_out.data (status count)", sent_q.size(), unmatched_drops);
      unmatched_drops = 0;
      sent_q.delete();
      if (errs == 0) begin
         pass_cnt++;
         $display("test %0d finished with no errors", num);
      end else begin
         fail_cnt++;
         $display("test %0d finished with %0d errors", num, errs);
      end
      errs = 0;
   endtask

   always @(posedge clk) begin
      if (!rst) begin
         if (trace_valid && en) begin
            sent_q.push_back(trace_data);
            sent_cnt++;
         end
         if (held && (!debug_out.valid || debug_out != held_flit)) begin
            note_failure("debug_out changed while debug_out_ready was low");
         end
         held = debug_out.valid & ~debug_out_ready;
         held_flit = debug_out;
         if (debug_out.valid && debug_out_ready) begin
            pkt[n_flits] = debug_out.data;
            n_flits++;
            if (debug_out.last) begin
               if (n_flits < 3) begin
                  note_failure("packet ended before its payload");
               end else begin
                  check_packet();
               end
               n_flits = 0;
            end else if (n_flits == 4) begin
               note_failure("last is missing on the final flit of a packet");
               n_flits = 0;
            end
         end
      end
   end

endmodule

// File: verilog/dii_pkg.sv
package dii_pkg;

   typedef struct packed {
      logic        valid;
      logic        last;
      logic [15:0] data;
   } dii_flit;

   typedef struct packed {
      logic        psel;
      logic        penable;
      logic        pwrite;
      logic [3:0]  paddr;
      logic [31:0] pwdata;
   } apb_req_t;

   typedef struct packed {
      logic [31:0] prdata;
      logic        pready;
      logic        pslverr;
   } apb_rsp_t;

endpackage

// File: verilog/osd_trace_packetization.sv
`timescale 1ns/100ps

module osd_trace_packetization
   import dii_pkg::*;
#(
   parameter int WIDTH = 32
) (
   input  logic             clk,
   input  logic             rst,
   input  logic [9:0]       id,
   input  logic [15:0]      dest,
   input  logic [WIDTH-1:0] trace_data,
   input  logic             trace_overflow,
   input  logic             trace_valid,
   output logic             trace_ready,
   output dii_flit          debug_out,
   input  logic             debug_out_ready
);

   localparam int NUM_FLITS = (WIDTH + 15) / 16;
   localparam int CNT_W = (NUM_FLITS > 1) ? $clog2(NUM_FLITS) : 1;

   typedef enum logic [1:0] {
      IDLE,
      SOURCE,
      STATUS,
      EVENT
   } state_t;

   state_t state;
   state_t nxt_state;
   logic [CNT_W-1:0] counter;
   logic [CNT_W-1:0] nxt_counter;
   logic [NUM_FLITS*16-1:0] padded;

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= IDLE;
         counter <= '0;
      end else begin
         state <= nxt_state;
         counter <= nxt_counter;
      end
   end

   always_comb begin
      padded = '0;
      padded[WIDTH-1:0] = trace_data; // upper bits of the final flit stay zero.
      trace_ready = 1'b0;
      debug_out.valid = 1'b0;
      debug_out.last = 1'b0;
      debug_out.data = 16'h0;
      nxt_state = state;
      nxt_counter = counter;
      case (state)
         IDLE: begin
            debug_out.data = dest;
            if (trace_valid) begin
               debug_out.valid = 1'b1;
               if (debug_out_ready) begin
                  nxt_state = SOURCE;
               end
            end
         end
         SOURCE: begin
            debug_out.valid = 1'b1;
            debug_out.data = {2'h2, 2'h0, trace_overflow, 1'b0, id}; // trace event class.
            nxt_counter = '0;
            if (debug_out_ready) begin
               nxt_state = trace_overflow ? STATUS : EVENT;
            end
         end
         STATUS: begin
            debug_out.valid = 1'b1;
            debug_out.last = 1'b1;
            debug_out.data = {1'b1, 5'h0, trace_data[9:0]};
            if (debug_out_ready) begin
               trace_ready = 1'b1;
               nxt_state = IDLE;
            end
         end
         EVENT: begin
            debug_out.valid = 1'b1;
            debug_out.data = padded[int'(counter)*16 +: 16];
            if (int'(counter) < NUM_FLITS - 1) begin
               if (debug_out_ready) begin
                  nxt_counter = counter + 1'b1;
               end
            end else begin
               debug_out.last = 1'b1;
               if (debug_out_ready) begin
                  trace_ready = 1'b1;
                  nxt_state = IDLE;
               end
            end
         end
         default: nxt_state = IDLE;
      endcase
   end

endmodule

// File: verilog/osd_trace_unit.sv
`timescale 1ns/100ps
`include "trace_consts.svh"

module osd_trace_unit
   import dii_pkg::*;
   import trace_pkg::*;
(
   input  logic                    clk,
   input  logic                    rst,
   input  apb_req_t                apb_in,
   output apb_rsp_t                apb_out,
   input  logic [`TRACE_WIDTH-1:0] trace_data,
   input  logic                    trace_valid,
   output dii_flit                 debug_out,
   input  logic                    debug_out_ready
);

   trace_cfg_t cfg;
   logic       drop_inc;
   trace_rec_t rec;
   logic       rec_valid;
   logic       rec_ready;
   trace_rec_t evt_head;
   logic       evt_valid;
   logic       evt_pop;
   dii_flit    pkt_flit;
   logic       pkt_ready;
   dii_flit    flit_head;
   logic       flit_valid;

   trace_cfg_apb u_cfg (
      .clk(clk), .rst(rst), .apb_in(apb_in), .apb_out(apb_out),
      .drop_inc(drop_inc), .cfg(cfg)
   );

   trace_overflow_tracker u_tracker (
      .clk(clk), .rst(rst), .enable(cfg.enable),
      .trace_data(trace_data), .trace_valid(trace_valid),
      .rec(rec), .rec_valid(rec_valid), .rec_ready(rec_ready), .drop_inc(drop_inc)
   );

   stream_fifo #(.T(trace_rec_t), .DEPTH(`EVT_FIFO_DEPTH)) u_evt_fifo (
      .clk(clk), .rst(rst), .in_data(rec), .in_valid(rec_valid), .in_ready(rec_ready),
      .out_data(evt_head), .out_valid(evt_valid), .out_ready(evt_pop)
   );

   osd_trace_packetization #(.WIDTH(`TRACE_WIDTH)) u_packetizer (
      .clk(clk), .rst(rst), .id(cfg.id), .dest(cfg.dest),
      .trace_data(evt_head.data), .trace_overflow(evt_head.overflow),
      .trace_valid(evt_valid), .trace_ready(evt_pop),
      .debug_out(pkt_flit), .debug_out_ready(pkt_ready)
   );

   stream_fifo #(.T(dii_flit), .DEPTH(`FLIT_FIFO_DEPTH)) u_flit_fifo (
      .clk(clk), .rst(rst), .in_data(pkt_flit), .in_valid(pkt_flit.valid),
      .in_ready(pkt_ready), .out_data(flit_head), .out_valid(flit_valid),
      .out_ready(debug_out_ready)
   );

   // the stored valid bit is always set, so the queue's own valid replaces it.
   assign debug_out.valid = flit_valid;
   assign debug_out.last = flit_head.last;
   assign debug_out.data = flit_head.data;

endmodule

// File: verilog/stream_fifo.sv
`timescale 1ns/100ps

module stream_fifo #(
   parameter type T = logic [7:0],
   parameter int DEPTH = 4
) (
   input  logic clk,
   input  logic rst,
   input  T     in_data,
   input  logic in_valid,
   output logic in_ready,
   output T     out_data,
   output logic out_valid,
   input  logic out_ready
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   T mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic push;
   logic pop;

   assign in_ready = (count < CNT_W'(DEPTH));
   assign out_valid = (count != '0);
   assign out_data = mem[rd_ptr];
   assign push = in_valid & in_ready;
   assign pop = out_valid & out_ready;

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= in_data;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count <= '0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         count <= count + CNT_W'(push) - CNT_W'(pop);
      end
   end

endmodule

// File: verilog/trace_cfg_apb.sv
`timescale 1ns/100ps
`include "trace_consts.svh"

module trace_cfg_apb
   import dii_pkg::*;
   import trace_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  apb_req_t   apb_in,
   output apb_rsp_t   apb_out,
   input  logic       drop_inc,
   output trace_cfg_t cfg
);

   logic [9:0]  id_q;
   logic [15:0] dest_q;
   logic        enable_q;
   logic [15:0] drop_total;
   logic        access;
   logic        mapped;
   logic        wr_ok;
   logic [31:0] rd_data;

   assign access = apb_in.psel & apb_in.penable;

   always_comb begin
      mapped = 1'b1;
      rd_data = 32'h0;
      case (apb_in.paddr)
         `REG_ID: rd_data = {22'h0, id_q};
         `REG_CTRL: rd_data = {31'h0, enable_q};
         `REG_DEST: rd_data = {16'h0, dest_q};
         `REG_DROPPED: rd_data = {16'h0, drop_total};
         default: mapped = 1'b0; // unaligned offsets fall here too.
      endcase
   end

   // the drop total is read only.
   assign wr_ok = mapped & (apb_in.paddr != `REG_DROPPED);

   assign apb_out.prdata = rd_data;
   assign apb_out.pready = 1'b1;
   assign apb_out.pslverr = access & (~mapped | (apb_in.pwrite & ~wr_ok));

   always_ff @(posedge clk) begin
      if (rst) begin
         id_q <= '0;
         dest_q <= '0;
         enable_q <= 1'b0;
      end else if (access & apb_in.pwrite & wr_ok) begin
         case (apb_in.paddr)
            `REG_ID: id_q <= apb_in.pwdata[9:0];
            `REG_CTRL: enable_q <= apb_in.pwdata[0];
            `REG_DEST: dest_q <= apb_in.pwdata[15:0];
            default: ;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         drop_total <= '0;
      end else if (drop_inc && drop_total != 16'hFFFF) begin
         drop_total <= drop_total + 1'b1; // saturates at the top.
      end
   end

   assign cfg.id = id_q;
   assign cfg.dest = dest_q;
   assign cfg.enable = enable_q;

endmodule

// File: verilog/trace_consts.svh
`ifndef TRACE_CONSTS_SVH
`define TRACE_CONSTS_SVH

`define TRACE_WIDTH 32
`define EVT_FIFO_DEPTH 4
`define FLIT_FIFO_DEPTH 2

`define DROP_CNT_MAX 10'd1023

`define REG_ID 4'h0
`define REG_CTRL 4'h4
`define REG_DEST 4'h8
`define REG_DROPPED 4'hC

`endif

// File: verilog/trace_overflow_tracker.sv
`timescale 1ns/100ps
`include "trace_consts.svh"

module trace_overflow_tracker
   import trace_pkg::*;
(
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    enable,
   input  logic [`TRACE_WIDTH-1:0] trace_data,
   input  logic                    trace_valid,
   output trace_rec_t              rec,
   output logic                    rec_valid,
   input  logic                    rec_ready,
   output logic                    drop_inc
);

   logic [9:0] drop_cnt;
   logic [9:0] nxt_drop_cnt;
   logic       offered;
   logic       pending;

   assign offered = trace_valid & enable;
   assign pending = (drop_cnt != '0);

   always_comb begin
      rec.overflow = pending;
      rec.data = pending ? `TRACE_WIDTH'(drop_cnt) : trace_data;
      rec_valid = rec_ready & (offered | pending); // only offered when the queue has room.
      drop_inc = 1'b0;
      nxt_drop_cnt = drop_cnt;
      if (offered) begin
         if (!rec_ready) begin
            drop_inc = 1'b1;
            if (drop_cnt != `DROP_CNT_MAX) begin
               nxt_drop_cnt = drop_cnt + 1'b1;
            end
         end else if (pending) begin
            drop_inc = 1'b1; // the event yields to the overflow record.
            nxt_drop_cnt = 10'd1;
         end
      end else if (pending && rec_ready) begin
         nxt_drop_cnt = '0;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         drop_cnt <= '0;
      end else begin
         drop_cnt <= nxt_drop_cnt;
      end
   end

endmodule

// File: verilog/trace_pkg.sv
`include "trace_consts.svh"

package trace_pkg;

   // a record is either a trace event or a report of dropped events.
   typedef struct packed {
      logic                    overflow;
      logic [`TRACE_WIDTH-1:0] data;
   } trace_rec_t;

   typedef struct packed {
      logic [9:0]  id;
      logic [15:0] dest;
      logic        enable;
   } trace_cfg_t;

endpackage
